//--- verilog/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// byte address width on every port
`define ADDR_W 32

// one cache line
`define LINE_W 256

// one burst beat on the memory side
`define BEAT_W 64

// beats needed to move a whole line
`define BEATS 4

// lines held by burst_ram, indexed by address bits 12:5
`define MEM_LINES 256

// read command to first beat
`define BMEM_LAT 4

`endif

//--- verilog/mem_pkg.sv
`include "mem_consts.svh"

package mem_pkg;

    // one 256-bit word seen either as a line or as its burst beats
    // beat[0] sits in the lowest 64 bits
    typedef union packed {
        logic [`LINE_W-1:0]               line;
        logic [`BEATS-1:0][`BEAT_W-1:0]   beat;
    } cacheline_u;

    // arbiter either forwards live requests or replays a buffered write
    typedef enum logic {
        PASS_THRU  = 1'b0,
        WAIT_WRITE = 1'b1
    } arb_state_e;

    // line adapter burst sequencing
    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        RD_CMD     = 3'd1,
        RD_COLLECT = 3'd2,
        RD_DONE    = 3'd3,
        WR_BEATS   = 3'd4
    } adapter_state_e;

endpackage

//--- verilog/bmem_arbiter.sv
`timescale 1ns/1ps

`include "mem_consts.svh"

module bmem_arbiter (
    input  logic                  clk,
    input  logic                  rst,

    // instruction cache, read only
    input  logic                  icache_read,
    input  logic [`ADDR_W-1:0]    icache_addr,
    output logic                  icache_ready,

    // data cache
    input  logic                  dcache_read,
    input  logic                  dcache_write,
    input  logic [`ADDR_W-1:0]    dcache_addr,
    input  mem_pkg::cacheline_u   dcache_wdata,
    output logic                  dcache_ready,

    // shared response, seen by both caches
    output mem_pkg::cacheline_u   icache_rdata,
    output logic                  icache_rvalid,
    output logic [`ADDR_W-1:0]    icache_raddr,
    output mem_pkg::cacheline_u   dcache_rdata,
    output logic                  dcache_rvalid,
    output logic [`ADDR_W-1:0]    dcache_raddr,

    // toward the line adapter
    output logic                  line_read,
    output logic                  line_write,
    output logic [`ADDR_W-1:0]    line_addr,
    output mem_pkg::cacheline_u   line_wdata,
    input  logic                  line_ready,
    input  mem_pkg::cacheline_u   line_rdata,
    input  logic                  line_rvalid,
    input  logic [`ADDR_W-1:0]    line_raddr
);

    import mem_pkg::*;

    arb_state_e            state;
    arb_state_e            state_next;

    logic [`ADDR_W-1:0]    addr_buf;
    cacheline_u            data_buf;

    // capture the write as it is first forwarded
    always_ff @(posedge clk) begin
        if (state == PASS_THRU && dcache_write) begin
            addr_buf <= dcache_addr;
            data_buf <= dcache_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= PASS_THRU;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            PASS_THRU: begin
                if (dcache_write) begin
                    state_next = WAIT_WRITE;
                end
            end
            WAIT_WRITE: begin
                if (line_ready) begin
                    state_next = PASS_THRU;
                end
            end
            default: state_next = PASS_THRU;
        endcase
    end

    // request routing, data cache always wins
    always_comb begin
        icache_ready = 1'b0;
        dcache_ready = 1'b0;
        line_read    = 1'b0;
        line_write   = 1'b0;
        line_addr    = '0;
        line_wdata   = '0;
        unique case (state)
            PASS_THRU: begin
                if (dcache_read || dcache_write) begin
                    line_read    = dcache_read;
                    line_write   = dcache_write;
                    line_addr    = dcache_addr;
                    line_wdata   = dcache_wdata;
                    dcache_ready = line_ready;
                end else if (icache_read) begin
                    line_read    = 1'b1;
                    line_addr    = icache_addr;
                    icache_ready = line_ready;
                end
            end
            WAIT_WRITE: begin
                // keep replaying until the adapter finishes the burst
                line_write   = 1'b1;
                line_addr    = addr_buf;
                line_wdata   = data_buf;
                dcache_ready = line_ready;
            end
            default: ;
        endcase
    end

    // each cache filters responses by raddr
    assign icache_rdata  = line_rdata;
    assign icache_rvalid = line_rvalid;
    assign icache_raddr  = line_raddr;
    assign dcache_rdata  = line_rdata;
    assign dcache_rvalid = line_rvalid;
    assign dcache_raddr  = line_raddr;

endmodule

//--- verilog/cacheline_adapter.sv
`timescale 1ns/1ps

`include "mem_consts.svh"

module cacheline_adapter (
    input  logic                  clk,
    input  logic                  rst,

    // line side, from the arbiter
    input  logic                  line_read,
    input  logic                  line_write,
    input  logic [`ADDR_W-1:0]    line_addr,
    input  mem_pkg::cacheline_u   line_wdata,
    output logic                  line_ready,
    output mem_pkg::cacheline_u   line_rdata,
    output logic                  line_rvalid,
    output logic [`ADDR_W-1:0]    line_raddr,

    // burst side, to burst_ram
    output logic                  bmem_read,
    output logic                  bmem_write,
    output logic [`ADDR_W-1:0]    bmem_addr,
    output logic [`BEAT_W-1:0]    bmem_wdata,
    input  logic [`BEAT_W-1:0]    bmem_rdata,
    input  logic                  bmem_rvalid
);

    import mem_pkg::*;

    localparam int BEAT_CW = $clog2(`BEATS);
    localparam logic [BEAT_CW-1:0] LAST_BEAT = BEAT_CW'(`BEATS - 1);

    adapter_state_e        state;
    adapter_state_e        state_next;
    logic [BEAT_CW-1:0]    beat_cnt;

    logic [`ADDR_W-1:0]    addr_q;
    cacheline_u            wdata_q;
    cacheline_u            rdata_q;

    logic                  last_beat;

    assign last_beat = (beat_cnt == LAST_BEAT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE: begin
                // writes take precedence if both levels ever show up
                if (line_write) begin
                    state_next = WR_BEATS;
                end else if (line_read) begin
                    state_next = RD_CMD;
                end
            end
            RD_CMD: state_next = RD_COLLECT;
            RD_COLLECT: begin
                if (bmem_rvalid && last_beat) begin
                    state_next = RD_DONE;
                end
            end
            RD_DONE: state_next = IDLE;
            WR_BEATS: begin
                if (last_beat) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // beat counter is shared by write walk and read collect
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (state == WR_BEATS) begin
            beat_cnt <= beat_cnt + 1'b1;
        end else if (state == RD_COLLECT && bmem_rvalid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end else if (state == IDLE) begin
            beat_cnt <= '0;
        end
    end

    // latch the request while idle
    always_ff @(posedge clk) begin
        if (state == IDLE && (line_read || line_write)) begin
            addr_q  <= line_addr;
            wdata_q <= line_wdata;
        end
    end

    // read beats land in their slot of the line
    always_ff @(posedge clk) begin
        if (state == RD_COLLECT && bmem_rvalid) begin
            rdata_q.beat[beat_cnt] <= bmem_rdata;
        end
    end

    // ready is never raised in IDLE, so a fresh request is not acked early
    assign line_ready  = (state == RD_CMD) || (state == WR_BEATS && last_beat);
    assign line_rvalid = (state == RD_DONE);
    assign line_rdata  = rdata_q;
    assign line_raddr  = addr_q;

    assign bmem_read   = (state == RD_CMD);
    assign bmem_write  = (state == WR_BEATS);
    assign bmem_addr   = addr_q;
    assign bmem_wdata  = wdata_q.beat[beat_cnt];

endmodule

//--- verilog/burst_ram.sv
`timescale 1ns/1ps

`include "mem_consts.svh"

module burst_ram (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  bmem_read,
    input  logic                  bmem_write,
    input  logic [`ADDR_W-1:0]    bmem_addr,
    input  logic [`BEAT_W-1:0]    bmem_wdata,
    output logic [`BEAT_W-1:0]    bmem_rdata,
    output logic                  bmem_rvalid
);

    localparam int IDX_LO  = $clog2(`LINE_W / 8);
    localparam int IDX_W   = $clog2(`MEM_LINES);
    localparam int BEAT_CW = $clog2(`BEATS);
    localparam int LAT_W   = $clog2(`BMEM_LAT + 1);

    // beat-addressed storage, {line, beat}
    logic [`BEAT_W-1:0]    mem [`MEM_LINES * `BEATS];
    // lines never written since reset read back as zero
    logic [`MEM_LINES-1:0] line_valid;

    logic [IDX_W-1:0]      idx;
    logic [IDX_W-1:0]      rd_line;
    logic [BEAT_CW-1:0]    wr_cnt;
    logic [BEAT_CW-1:0]    rd_cnt;
    logic [LAT_W-1:0]      lat_cnt;
    logic                  rd_load;

    assign idx = bmem_addr[IDX_LO +: IDX_W];

    // next beat goes out when latency expires or the stream continues
    assign rd_load = (lat_cnt == LAT_W'(1)) || (bmem_rvalid && rd_cnt != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid  <= '0;
            wr_cnt      <= '0;
            rd_cnt      <= '0;
            lat_cnt     <= '0;
            bmem_rvalid <= 1'b0;
        end else begin
            if (bmem_write) begin
                line_valid[idx] <= 1'b1;
                wr_cnt          <= wr_cnt + 1'b1;
            end
            if (bmem_read) begin
                lat_cnt <= LAT_W'(`BMEM_LAT);
            end else if (lat_cnt != '0) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
            // rd_cnt wraps to zero after the last beat, ending the stream
            if (rd_load) begin
                bmem_rvalid <= 1'b1;
                rd_cnt      <= rd_cnt + 1'b1;
            end else begin
                bmem_rvalid <= 1'b0;
                rd_cnt      <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bmem_read) begin
            rd_line <= idx;
        end
        if (bmem_write) begin
            mem[{idx, wr_cnt}] <= bmem_wdata;
        end
        if (rd_load) begin
            bmem_rdata <= line_valid[rd_line] ? mem[{rd_line, rd_cnt}] : '0;
        end
    end

endmodule

//--- verilog/mem_subsys.sv
`timescale 1ns/1ps

`include "mem_consts.svh"

module mem_subsys (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  icache_read,
    input  logic [`ADDR_W-1:0]    icache_addr,
    output logic                  icache_ready,

    input  logic                  dcache_read,
    input  logic                  dcache_write,
    input  logic [`ADDR_W-1:0]    dcache_addr,
    input  mem_pkg::cacheline_u   dcache_wdata,
    output logic                  dcache_ready,

    output mem_pkg::cacheline_u   icache_rdata,
    output logic                  icache_rvalid,
    output logic [`ADDR_W-1:0]    icache_raddr,
    output mem_pkg::cacheline_u   dcache_rdata,
    output logic                  dcache_rvalid,
    output logic [`ADDR_W-1:0]    dcache_raddr
);

    import mem_pkg::*;

    // arbiter to adapter
    logic                  line_read;
    logic                  line_write;
    logic [`ADDR_W-1:0]    line_addr;
    cacheline_u            line_wdata;
    logic                  line_ready;
    cacheline_u            line_rdata;
    logic                  line_rvalid;
    logic [`ADDR_W-1:0]    line_raddr;

    // adapter to burst memory
    logic                  bmem_read;
    logic                  bmem_write;
    logic [`ADDR_W-1:0]    bmem_addr;
    logic [`BEAT_W-1:0]    bmem_wdata;
    logic [`BEAT_W-1:0]    bmem_rdata;
    logic                  bmem_rvalid;

    bmem_arbiter arbiter (
        .clk           (clk),
        .rst           (rst),
        .icache_read   (icache_read),
        .icache_addr   (icache_addr),
        .icache_ready  (icache_ready),
        .dcache_read   (dcache_read),
        .dcache_write  (dcache_write),
        .dcache_addr   (dcache_addr),
        .dcache_wdata  (dcache_wdata),
        .dcache_ready  (dcache_ready),
        .icache_rdata  (icache_rdata),
        .icache_rvalid (icache_rvalid),
        .icache_raddr  (icache_raddr),
        .dcache_rdata  (dcache_rdata),
        .dcache_rvalid (dcache_rvalid),
        .dcache_raddr  (dcache_raddr),
        .line_read     (line_read),
        .line_write    (line_write),
        .line_addr     (line_addr),
        .line_wdata    (line_wdata),
        .line_ready    (line_ready),
        .line_rdata    (line_rdata),
        .line_rvalid   (line_rvalid),
        .line_raddr    (line_raddr)
    );

    cacheline_adapter adapter (
        .clk         (clk),
        .rst         (rst),
        .line_read   (line_read),
        .line_write  (line_write),
        .line_addr   (line_addr),
        .line_wdata  (line_wdata),
        .line_ready  (line_ready),
        .line_rdata  (line_rdata),
        .line_rvalid (line_rvalid),
        .line_raddr  (line_raddr),
        .bmem_read   (bmem_read),
        .bmem_write  (bmem_write),
        .bmem_addr   (bmem_addr),
        .bmem_wdata  (bmem_wdata),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid)
    );

    burst_ram ram (
        .clk         (clk),
        .rst         (rst),
        .bmem_read   (bmem_read),
        .bmem_write  (bmem_write),
        .bmem_addr   (bmem_addr),
        .bmem_wdata  (bmem_wdata),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid)
    );

endmodule

//--- testbench/mem_subsys_tb.sv
`timescale 1ns/1ps

`include "mem_consts.svh"

module mem_subsys_tb;

    import mem_pkg::*;

    localparam int TIMEOUT      = 64;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_STEPS    = 32;
    // request to rvalid on an idle subsystem
    localparam int READ_LAT     = 2 + `BMEM_LAT + `BEATS;

    typedef enum int {IREAD, DREAD, DWRITE, PAIR} step_kind_e;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 icache_read;
    logic [`ADDR_W-1:0]   icache_addr;
    logic                 icache_ready;
    logic                 dcache_read;
    logic                 dcache_write;
    logic [`ADDR_W-1:0]   dcache_addr;
    cacheline_u           dcache_wdata;
    logic                 dcache_ready;
    cacheline_u           icache_rdata;
    logic                 icache_rvalid;
    logic [`ADDR_W-1:0]   icache_raddr;
    cacheline_u           dcache_rdata;
    logic                 dcache_rvalid;
    logic [`ADDR_W-1:0]   dcache_raddr;

    // stimulus table with one row per transaction
    // an expected latency of 0 leaves the timing unchecked
    string                step_name [MAX_STEPS];
    step_kind_e           step_kind [MAX_STEPS];
    logic [`ADDR_W-1:0]   step_addr [MAX_STEPS];
    cacheline_u           step_wdata [MAX_STEPS];
    int                   step_lat [MAX_STEPS];
    int                   n_steps = 0;

    // reference memory keyed by line index
    // lines never written read as zero
    cacheline_u           ref_mem [int];

    integer               seed = 32'hccd44f44;
    int                   cycle_cnt = 0;
    int                   iready_cnt = 0;
    int                   dready_cnt = 0;
    int                   rvalid_cnt = 0;

    mem_subsys uut (.*);

    always #2 clk = ~clk;

    // pulse counters sample the outputs before each edge updates the DUT
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (icache_ready)
            iready_cnt <= iready_cnt + 1;
        if (dcache_ready)
            dready_cnt <= dready_cnt + 1;
        if (icache_rvalid)
            rvalid_cnt <= rvalid_cnt + 1;
    end

    // line index is address bits 12:5
    function automatic int line_key(input logic [`ADDR_W-1:0] addr);
        return int'(addr[12:5]);
    endfunction

    function automatic cacheline_u ref_read(input logic [`ADDR_W-1:0] addr);
        cacheline_u line;
        line = '0;
        if (ref_mem.exists(line_key(addr)))
            line = ref_mem[line_key(addr)];
        return line;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected)
            stop_run($sformatf("Mismatch in %s: expected %h, actual %h",
                               name, expected, actual));
    endtask

    task automatic add_step(input string name, input step_kind_e kind,
                            input logic [`ADDR_W-1:0] addr, input int exp_lat);
        int b;
        step_name[n_steps] = name;
        step_kind[n_steps] = kind;
        step_addr[n_steps] = addr;
        step_lat[n_steps]  = exp_lat;
        for (b = 0; b < `BEATS; b++)
            step_wdata[n_steps].beat[b] = {$random(seed), $random(seed)};
        n_steps++;
    endtask

    task automatic run_step(input int i);
        bit                 i_want;
        bit                 d_want;
        bit                 i_done;
        bit                 d_done;
        bit                 got_i;
        bit                 got_d;
        int                 waited;
        int                 start_cnt;
        int                 iready_0;
        int                 dready_0;
        int                 rvalid_0;
        int                 b;
        cacheline_u         expected;
        cacheline_u         actual;
        logic [`ADDR_W-1:0] raddr;

        i_want   = (step_kind[i] == IREAD || step_kind[i] == PAIR);
        d_want   = (step_kind[i] != IREAD);
        iready_0 = iready_cnt;
        dready_0 = dready_cnt;
        rvalid_0 = rvalid_cnt;
        @(posedge clk);
        icache_read  <= i_want;
        icache_addr  <= step_addr[i];
        dcache_read  <= (step_kind[i] == DREAD);
        dcache_write <= (step_kind[i] == DWRITE || step_kind[i] == PAIR);
        dcache_addr  <= step_addr[i];
        dcache_wdata <= step_wdata[i];
        i_done = !i_want;
        d_done = !d_want;
        @(negedge clk);
        start_cnt = cycle_cnt;

        // hold each request level until its ready pulse
        waited = 0;
        while (!(i_done && d_done)) begin
            if (waited == TIMEOUT)
                stop_run($sformatf("%s: no ready came within %0d cycles",
                                   step_name[i], TIMEOUT));
            if (icache_ready && !d_done)
                stop_run($sformatf("%s: icache was served before the pending dcache request",
                                   step_name[i]));
            got_i = icache_ready && !i_done;
            got_d = dcache_ready && !d_done;
            if (got_d && step_kind[i] != DREAD)
                ref_mem[line_key(step_addr[i])] = step_wdata[i];
            @(posedge clk);
            if (got_i) begin
                icache_read <= 1'b0;
                i_done = 1'b1;
            end
            if (got_d) begin
                dcache_read  <= 1'b0;
                dcache_write <= 1'b0;
                d_done = 1'b1;
            end
            @(negedge clk);
            waited++;
        end

        if (step_kind[i] != DWRITE) begin
            waited = 0;
            while (!icache_rvalid) begin
                if (waited == TIMEOUT)
                    stop_run($sformatf("%s: no read data came within %0d cycles",
                                       step_name[i], TIMEOUT));
                @(negedge clk);
                waited++;
            end
            // both caches see every response
            check_value({step_name[i], " dcache rvalid"}, 64'd1, dcache_rvalid);
            actual   = (step_kind[i] == DREAD) ? dcache_rdata : icache_rdata;
            raddr    = (step_kind[i] == DREAD) ? dcache_raddr : icache_raddr;
            expected = ref_read(step_addr[i]);
            for (b = 0; b < `BEATS; b++)
                check_value($sformatf("%s beat %0d", step_name[i], b),
                            expected.beat[b], actual.beat[b]);
            check_value({step_name[i], " raddr"}, step_addr[i], raddr);
            if (step_lat[i] != 0)
                check_value({step_name[i], " latency"}, step_lat[i], cycle_cnt - start_cnt);
        end

        // expect one ready per request and one rvalid per read, none for writes
        repeat (2) @(negedge clk);
        check_value({step_name[i], " icache ready pulses"}, i_want, iready_cnt - iready_0);
        check_value({step_name[i], " dcache ready pulses"}, d_want, dready_cnt - dready_0);
        check_value({step_name[i], " rvalid pulses"}, step_kind[i] != DWRITE,
                    rvalid_cnt - rvalid_0);
    endtask

    initial begin
        int c;
        int i;

        rst          <= 1'b1;
        icache_read  <= 1'b0;
        icache_addr  <= '0;
        dcache_read  <= 1'b0;
        dcache_write <= 1'b0;
        dcache_addr  <= '0;
        dcache_wdata <= '0;

        add_step("unwritten read", IREAD, 32'h0000_0124, READ_LAT);
        add_step("write a", DWRITE, 32'h0000_0040, 0);
        add_step("dcache read a", DREAD, 32'h0000_0040, READ_LAT);
        add_step("icache read a", IREAD, 32'h0000_0040, READ_LAT);
        add_step("priority pair", PAIR, 32'h0000_0280, 0);
        // same low bits as a but a different line index
        add_step("write b", DWRITE, 32'h0000_1040, 0);
        add_step("write c", DWRITE, 32'h0000_1fe0, 0);
        add_step("icache read a after b", IREAD, 32'h0000_0040, READ_LAT);
        add_step("dcache read b", DREAD, 32'h0000_1040, READ_LAT);
        add_step("write d", DWRITE, 32'h0000_0000, 0);
        add_step("icache read c", IREAD, 32'h0000_1fe0, READ_LAT);
        add_step("rewrite a", DWRITE, 32'h0000_0040, 0);
        add_step("dcache read d", DREAD, 32'h0000_0000, READ_LAT);
        add_step("dcache read new a", DREAD, 32'h0000_0040, READ_LAT);
        add_step("icache read b", IREAD, 32'h0000_1040, READ_LAT);
        add_step("unwritten read e", DREAD, 32'h0000_0aa0, READ_LAT);

        for (c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            if (c == RESET_CYCLES - 1)
                rst <= 1'b0;
            @(negedge clk);
            check_value("reset quiet", '0,
                        {icache_ready, dcache_ready, icache_rvalid, dcache_rvalid});
        end
        repeat (3) begin
            @(negedge clk);
            check_value("quiet after reset", '0,
                        {icache_ready, dcache_ready, icache_rvalid, dcache_rvalid});
        end

        for (i = 0; i < n_steps; i++)
            run_step(i);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- mem_subsys.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/bmem_arbiter.sv
verilog/cacheline_adapter.sv
verilog/burst_ram.sv
verilog/mem_subsys.sv
testbench/mem_subsys_tb.sv

//--- Bender.yml
package:
  name: mem_subsys

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mem_pkg.sv
      - verilog/bmem_arbiter.sv
      - verilog/cacheline_adapter.sv
      - verilog/burst_ram.sv
      - verilog/mem_subsys.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/mem_subsys_tb.sv
